/* bus_decode.sv */
// ------------------------------------------------
// Bus master select and address decode
// DMA takes the bus whenever it asks for it. The
// selected address drives the region selects and
// the sprite DMA trigger
// ------------------------------------------------

module bus_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,
	input  nes_bus_pkg::cpu_bus_t cpu,
	input  dma_pkg::dma_req_t     dma,
	output nes_bus_pkg::bus_req_t bus,
	output nes_bus_pkg::region_t  region,
	output logic                  oam_trigger
);

	logic                  cpu_hold;  // CPU off the bus until first ce after reset
	nes_bus_pkg::bus_req_t cpu_req;
	nes_bus_pkg::addr_t    sel_addr;

	// CPU comes out of reset on its first enable
	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_hold <= 1'b1;
		end else if (ce) begin
			cpu_hold <= 1'b0;
		end
	end

	// Split rnw into strobes
	always_comb begin
		cpu_req.addr  = cpu.addr;
		cpu_req.rd    = !cpu_hold && cpu.rnw;
		cpu_req.wr    = !cpu_hold && !cpu.rnw;
		cpu_req.wdata = cpu.wdata;
	end

	assign bus      = dma.enable ? dma.req : cpu_req;  // DMA wins
	assign sel_addr = bus.addr;

	always_comb begin
		region.ppu_sel = sel_addr >= nes_bus_pkg::PPU_BASE
			&& sel_addr < nes_bus_pkg::PPU_END;   // Mirrored 8 regs
		region.apu_sel = sel_addr >= nes_bus_pkg::APU_BASE
			&& sel_addr < nes_bus_pkg::APU_END;   // Joypads live in here too
		region.apu_status_sel = sel_addr == nes_bus_pkg::APU_STATUS_ADDR;
		region.joy1_sel       = sel_addr == nes_bus_pkg::JOY1_ADDR;
		region.joy2_sel       = sel_addr == nes_bus_pkg::JOY2_ADDR;
		// Internal RAM below the PPU, cart space above the IO block
		region.mem_sel = sel_addr < nes_bus_pkg::PPU_BASE
			|| sel_addr >= nes_bus_pkg::IO_END;
	end

	// Write to 4014h kicks off sprite DMA
	assign oam_trigger = ce && bus.wr && sel_addr == nes_bus_pkg::OAM_DMA_ADDR;

	// Main regions never overlap, whoever owns the bus
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({region.ppu_sel, region.apu_sel, region.mem_sel}))
		else $error("bus_decode: overlapping region selects at %h", sel_addr);

endmodule

/* dma_engine.sv */
// ------------------------------------------------
// Sprite and DMC sample DMA with the cycle parity
// Sprite DMA reads on even cycles and writes OAM on
// odd ones. A DMC fetch steals an even cycle and the
// sprite transfer then resumes where it stopped
// ------------------------------------------------

module dma_engine (
	input  logic               clk,
	input  logic               reset,
	input  logic               ce,
	input  logic               oam_trigger,
	input  logic               cpu_rnw,
	input  nes_bus_pkg::data_t cpu_wdata,
	input  nes_bus_pkg::data_t read_data,
	input  logic               dmc_request,   // Level from the APU
	input  nes_bus_pkg::addr_t dmc_addr,
	output dma_pkg::dma_req_t  dma,
	output logic               pause_cpu,
	output logic               dmc_ack,       // One cycle pulse
	output logic               odd_cycle
);

	dma_pkg::spr_state_t spr_state;
	dma_pkg::dmc_state_t dmc_state;
	nes_bus_pkg::data_t  spr_page;    // Source page high byte
	logic [7:0]          spr_index;   // Byte within page
	nes_bus_pkg::data_t  spr_byte;    // Read data held for the OAM write
	logic                spr_last;

	assign spr_last = spr_index == 8'(dma_pkg::OAM_PAGE_LEN - 1);

	// APU cycle parity, odd out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b1;
		end else if (ce) begin
			odd_cycle <= !odd_cycle;
		end
	end

	// DMC grant on an even read cycle, ack on the following even one
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= dma_pkg::DMC_IDLE;
		end else if (ce) begin
			case (dmc_state)
				dma_pkg::DMC_IDLE: begin
					if (dmc_request && cpu_rnw && !odd_cycle)
						dmc_state <= dma_pkg::DMC_GRANT;
				end
				dma_pkg::DMC_GRANT: begin
					if (!odd_cycle)
						dmc_state <= dma_pkg::DMC_IDLE;  // Ack cycle done
				end
				default: dmc_state <= dma_pkg::DMC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= dma_pkg::SPR_IDLE;
		end else if (ce) begin
			if (oam_trigger) begin
				spr_state <= dma_pkg::SPR_WAIT;
			end else begin
				case (spr_state)
					dma_pkg::SPR_WAIT: begin
						// Align so the first transfer cycle is an even read
						if (cpu_rnw && odd_cycle)
							spr_state <= dma_pkg::SPR_XFER;
					end
					dma_pkg::SPR_XFER: begin
						if (!odd_cycle && dmc_state == dma_pkg::DMC_GRANT)
							spr_state <= dma_pkg::SPR_WAIT;   // DMC steals this slot
						else if (odd_cycle && spr_last)
							spr_state <= dma_pkg::SPR_IDLE;   // 256th write
					end
					default: spr_state <= dma_pkg::SPR_IDLE;
				endcase
			end
		end
	end

	// Page, index and data byte
	always_ff @(posedge clk) begin
		if (oam_trigger) begin
			spr_page  <= cpu_wdata;
			spr_index <= '0;
		end else if (ce && spr_state == dma_pkg::SPR_XFER && odd_cycle) begin
			spr_index <= spr_index + 8'd1;  // Advance after each OAM write
		end
		if (ce && spr_state == dma_pkg::SPR_XFER)
			spr_byte <= read_data;
	end

	assign dmc_ack   = dmc_state == dma_pkg::DMC_GRANT && !odd_cycle;
	assign pause_cpu = spr_state != dma_pkg::SPR_IDLE || dmc_request;

	always_comb begin
		dma.enable    = dmc_ack || spr_state == dma_pkg::SPR_XFER;
		dma.req.rd    = dma.enable && !odd_cycle;
		dma.req.wr    = dma.enable && odd_cycle;
		dma.req.wdata = spr_byte;
		if (dmc_ack)
			dma.req.addr = dmc_addr;                    // Sample fetch
		else if (!odd_cycle)
			dma.req.addr = {spr_page, spr_index};       // Sprite source
		else
			dma.req.addr = nes_bus_pkg::OAM_DATA_ADDR;  // OAM data port
	end

	// DMC fetch only lands in an even slot
	assert property (@(posedge clk) disable iff (reset) dmc_ack |-> !odd_cycle)
		else $error("dma_engine: dmc_ack on an odd cycle");

	// CPU must be stalled while DMA drives the bus
	assert property (@(posedge clk) disable iff (reset) dma.enable |-> pause_cpu)
		else $error("dma_engine: DMA owns bus without pause_cpu");

endmodule

/* dma_pkg.sv */
// ------------------------------------------------
// DMA controller definitions
// State encodings, sprite page length and the
// request the DMA hands to the bus decoder
// ------------------------------------------------

package dma_pkg;

	// Sprite DMA
	// SPR_WAIT is both the alignment wait and a cycle stolen by DMC
	typedef enum logic [1:0] {
		SPR_IDLE,
		SPR_WAIT,
		SPR_XFER
	} spr_state_t;

	// DMC sample fetch
	typedef enum logic {
		DMC_IDLE,
		DMC_GRANT
	} dmc_state_t;

	// DMA wants the bus when enable is set
	typedef struct packed {
		logic                  enable;
		nes_bus_pkg::bus_req_t req;
	} dma_req_t;

	localparam int OAM_PAGE_LEN = 256;  // Bytes per sprite page

endpackage

/* filelist.f */
+incdir+.
nes_bus_pkg.sv
dma_pkg.sv
bus_decode.sv
dma_engine.sv
read_data_path.sv
nes_bus_dma_top.sv
tb_nes_bus_dma.sv

/* nes_bus_dma_top.sv */
// ------------------------------------------------
// CPU-side bus of the console core
// Connects the decoder, the DMA engine and the read
// data path. CPU, APU, PPU and memory sit outside
// ------------------------------------------------

module nes_bus_dma_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,            // CPU cycle enable
	input  nes_bus_pkg::cpu_bus_t cpu,
	input  logic                  dmc_request,
	input  nes_bus_pkg::addr_t    dmc_addr,
	input  nes_bus_pkg::data_t    mem_din,
	input  nes_bus_pkg::data_t    ppu_dout,
	input  nes_bus_pkg::data_t    apu_status,
	input  nes_bus_pkg::joy_t     joypad1_data,
	input  nes_bus_pkg::joy_t     joypad2_data,
	output nes_bus_pkg::bus_req_t bus,
	output nes_bus_pkg::data_t    cpu_din,
	output logic                  pause_cpu,     // To CPU ready
	output logic                  dmc_ack,
	output logic                  odd_cycle,     // APU parity
	output logic [nes_bus_pkg::JOY_STROBE_BITS-1:0] joypad_out,
	output logic [1:0]            joypad_clock
);

	dma_pkg::dma_req_t    dma;
	nes_bus_pkg::region_t region;
	logic                 oam_trigger;

	bus_decode bus_decode_inst (
		.clk         (clk),
		.reset       (reset),
		.ce          (ce),
		.cpu         (cpu),
		.dma         (dma),
		.bus         (bus),
		.region      (region),
		.oam_trigger (oam_trigger)
	);

	dma_engine dma_engine_inst (
		.clk         (clk),
		.reset       (reset),
		.ce          (ce),
		.oam_trigger (oam_trigger),
		.cpu_rnw     (cpu.rnw),
		.cpu_wdata   (cpu.wdata),   // Page number on 4014h write
		.read_data   (cpu_din),     // Sprite source byte
		.dmc_request (dmc_request),
		.dmc_addr    (dmc_addr),
		.dma         (dma),
		.pause_cpu   (pause_cpu),
		.dmc_ack     (dmc_ack),
		.odd_cycle   (odd_cycle)
	);

	read_data_path read_data_path_inst (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.bus          (bus),
		.region       (region),
		.mem_din      (mem_din),
		.ppu_dout     (ppu_dout),
		.apu_status   (apu_status),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.cpu_din      (cpu_din),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

endmodule

/* nes_bus_pkg.sv */
// ------------------------------------------------
// CPU-side bus definitions of the console core
// Widths, memory map addresses and the bus structs
// shared by the decoder, the DMA and the read path
// ------------------------------------------------

package nes_bus_pkg;

	typedef logic [15:0] addr_t;  // CPU address
	typedef logic [7:0]  data_t;  // Data byte
	typedef logic [4:0]  joy_t;   // Serial pad data lines

	// What the CPU core drives
	typedef struct packed {
		addr_t addr;
		logic  rnw;    // 1 = read
		data_t wdata;
	} cpu_bus_t;

	// Access that actually goes on the bus
	typedef struct packed {
		addr_t addr;
		logic  rd;
		logic  wr;
		data_t wdata;
	} bus_req_t;

	// One-hot-ish register region selects
	typedef struct packed {
		logic ppu_sel;
		logic apu_sel;
		logic apu_status_sel;
		logic joy1_sel;
		logic joy2_sel;
		logic mem_sel;
	} region_t;

	// Memory map
	localparam addr_t PPU_BASE        = 16'h2000;
	localparam addr_t PPU_END         = 16'h4000;  // Exclusive
	localparam addr_t APU_BASE        = 16'h4000;
	localparam addr_t APU_END         = 16'h4018;  // Exclusive
	localparam addr_t APU_STATUS_ADDR = 16'h4015;
	localparam addr_t JOY1_ADDR       = 16'h4016;  // Strobe on write
	localparam addr_t JOY2_ADDR       = 16'h4017;
	localparam addr_t OAM_DMA_ADDR    = 16'h4014;  // Sprite DMA page
	localparam addr_t OAM_DATA_ADDR   = 16'h2004;  // PPU OAM data port
	localparam addr_t IO_END          = 16'h4020;  // Cart space from here

	localparam int JOY_STROBE_BITS = 3;  // Pad strobe/expansion lines

endpackage

/* read_data_path.sv */
// ------------------------------------------------
// Read data toward the CPU and the joypad port
// Muxes the source picked by the decoder, keeps the
// open-bus value and drives pad strobe and clocks
// ------------------------------------------------

module read_data_path (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,
	input  nes_bus_pkg::bus_req_t bus,
	input  nes_bus_pkg::region_t  region,
	input  nes_bus_pkg::data_t    mem_din,
	input  nes_bus_pkg::data_t    ppu_dout,
	input  nes_bus_pkg::data_t    apu_status,
	input  nes_bus_pkg::joy_t     joypad1_data,
	input  nes_bus_pkg::joy_t     joypad2_data,
	output nes_bus_pkg::data_t    cpu_din,
	output logic [nes_bus_pkg::JOY_STROBE_BITS-1:0] joypad_out,
	output logic [1:0]            joypad_clock
);

	nes_bus_pkg::data_t open_bus;  // Last value seen on the data bus

	// Bus capacitance holds the last byte
	always_ff @(posedge clk) begin
		open_bus <= cpu_din;
	end

	always_comb begin
		if (region.joy1_sel) begin
			cpu_din = {open_bus[7:5], joypad1_data};  // Upper bits float
		end else if (region.joy2_sel) begin
			cpu_din = {open_bus[7:5], joypad2_data};
		end else if (region.apu_status_sel) begin
			cpu_din = apu_status;
		end else if (region.apu_sel) begin
			cpu_din = open_bus;                       // Write-only APU regs
		end else if (region.ppu_sel) begin
			cpu_din = ppu_dout;
		end else if (region.mem_sel) begin
			cpu_din = mem_din;
		end else begin
			cpu_din = open_bus;  // 4018h..401Fh test regs
		end
	end

	// Pad strobe latch
	always_ff @(posedge clk) begin
		if (reset) begin
			joypad_out <= '0;
		end else if (ce && bus.wr && region.joy1_sel) begin
			joypad_out <= bus.wdata[nes_bus_pkg::JOY_STROBE_BITS-1:0];
		end
	end

	// One shift clock per read of each pad port
	assign joypad_clock = {ce && bus.rd && region.joy2_sel,
		ce && bus.rd && region.joy1_sel};

endmodule

/* tb_tasks.svh */
// ------------------------------------------------
// Directed tests for the bus and DMA testbench
// Included inside the testbench module, uses its
// signals and its read/write helpers
// ------------------------------------------------

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_reset_state();
	@(negedge clk);  // First cycle out of reset
	assert (!pause_cpu && !dmc_ack) else report_mismatch("pause_cpu or dmc_ack set after reset");
	assert (!bus.rd && !bus.wr) else report_mismatch("bus strobe active after reset");
	assert (joypad_clock == 2'b00) else report_mismatch("joypad_clock active after reset");
	assert (odd_cycle) else report_mismatch("odd_cycle not 1 after reset");
	@(negedge clk);
	assert (!odd_cycle) else report_mismatch("odd_cycle did not toggle on ce");
endtask

task automatic decode_reads();
	cpu_read(16'h0123, model_byte(16'h0123));  // Internal RAM
	cpu_read(16'h2002, PPU_VAL);
	cpu_read(nes_bus_pkg::APU_STATUS_ADDR, APU_STATUS_VAL);
	cpu_read(16'h4018, last_byte);  // Open bus
	cpu_read(16'hC0DE, model_byte(16'hC0DE));  // Cart space
	cpu_read(16'h4001, last_byte);  // Write-only APU register
endtask

task automatic joypad_port();
	nes_bus_pkg::joy_t j1;
	nes_bus_pkg::joy_t j2;
	j1 = nes_bus_pkg::joy_t'($random(seed));
	j2 = nes_bus_pkg::joy_t'($random(seed));
	@(posedge clk);
	joypad1_data <= j1;
	joypad2_data <= j2;
	cpu_write(nes_bus_pkg::JOY1_ADDR, 8'hA5);
	cpu_read(16'h0040, 8'h40);  // Known open-bus top bits
	assert (joypad_out == 3'b101)
		else report_mismatch($sformatf("joypad_out %b, expected 101", joypad_out));
	cpu_read(nes_bus_pkg::JOY1_ADDR, {last_byte[7:5], j1});
	cpu_read(nes_bus_pkg::JOY2_ADDR, {last_byte[7:5], j2});
	cpu_read(16'h0040, 8'h40);  // Clocks drop again
endtask

// Triggers one sprite page and follows the bus until pause_cpu falls
task automatic run_sprite_dma(input nes_bus_pkg::data_t page, input bit with_dmc);
	int                 rd_n;    // Sprite reads seen
	int                 wr_n;    // OAM writes seen
	int                 acks;
	int                 cycles;
	bit                 raised;
	nes_bus_pkg::addr_t dmc_a;
	rd_n   = 0;
	wr_n   = 0;
	acks   = 0;
	cycles = 0;
	raised = 1'b0;
	dmc_a  = nes_bus_pkg::addr_t'($random(seed));
	dmc_a[15] = 1'b1;  // Sample fetch from cart space
	cpu_write(nes_bus_pkg::OAM_DMA_ADDR, page);
	@(posedge clk);
	cpu.addr <= HOLD_ADDR;
	cpu.rnw  <= 1'b1;
	@(negedge clk);
	assert (pause_cpu) else report_mismatch("pause_cpu not raised by the 4014h write");
	while (pause_cpu) begin
		assert (wr_n < dma_pkg::OAM_PAGE_LEN)
			else report_mismatch("pause_cpu still high after the last OAM write");
		if (dmc_ack) begin
			assert (bus.rd && bus.addr == dmc_a && cpu_din == model_byte(dmc_a))
				else report_mismatch($sformatf("DMC read at %h, expected %h", bus.addr, dmc_a));
			acks++;
		end else if (bus.wr) begin
			assert (bus.addr == nes_bus_pkg::OAM_DATA_ADDR && rd_n == wr_n + 1)
				else report_mismatch($sformatf("OAM write %0d at %h out of order", wr_n, bus.addr));
			assert (bus.wdata == model_byte({page, 8'(wr_n)}))
				else report_mismatch($sformatf("OAM write %0d data %h", wr_n, bus.wdata));
			wr_n++;
		end else if (bus.rd && bus.addr != HOLD_ADDR) begin
			assert (bus.addr == {page, 8'(rd_n)} && rd_n == wr_n)
				else report_mismatch($sformatf("sprite read %0d at %h", rd_n, bus.addr));
			rd_n++;
		end
		cycles++;
		if (cycles > DMA_CYCLES + 16)
			abort_run($sformatf("Sprite DMA did not end within %0d cycles", DMA_CYCLES + 16));
		@(posedge clk);
		if (with_dmc && !raised && rd_n >= 40) begin
			dmc_request <= 1'b1;  // Cut in mid-transfer
			dmc_addr    <= dmc_a;
			raised = 1'b1;
		end
		if (acks > 0)
			dmc_request <= 1'b0;
		@(negedge clk);
	end
	assert (rd_n == dma_pkg::OAM_PAGE_LEN && wr_n == dma_pkg::OAM_PAGE_LEN)
		else report_mismatch($sformatf("%0d reads and %0d writes in the page", rd_n, wr_n));
	assert (acks == (with_dmc ? 1 : 0))
		else report_mismatch($sformatf("%0d DMC acks seen", acks));
endtask

task automatic sprite_page_copy();
	run_sprite_dma(8'h03, 1'b0);
endtask

task automatic dmc_cut_in();
	run_sprite_dma(8'h07, 1'b1);
endtask

`endif

/* tb_nes_bus_dma.sv */
// ------------------------------------------------
// Testbench for the CPU-side bus and DMA block
// Models memory, PPU, APU status and the pads around
// the DUT and runs the directed tests in tb_tasks.svh
// ------------------------------------------------

module tb_nes_bus_dma;

	localparam int CLK_PERIOD = 20;
	localparam int DMA_CYCLES = 2 * dma_pkg::OAM_PAGE_LEN + 2;  // 514 per sprite page
	localparam int WATCHDOG_CYCLES = 4000;  // Two DMAs plus the short tests, wide margin

	localparam nes_bus_pkg::data_t PPU_VAL        = 8'h5A;
	localparam nes_bus_pkg::data_t APU_STATUS_VAL = 8'h6B;
	localparam nes_bus_pkg::addr_t HOLD_ADDR      = 16'h8000;  // CPU parks here during DMA

	logic                  clk;
	logic                  reset;
	logic                  ce;
	nes_bus_pkg::cpu_bus_t cpu;
	logic                  dmc_request;
	nes_bus_pkg::addr_t    dmc_addr;
	nes_bus_pkg::data_t    mem_din;
	nes_bus_pkg::data_t    ppu_dout;
	nes_bus_pkg::data_t    apu_status;
	nes_bus_pkg::joy_t     joypad1_data;
	nes_bus_pkg::joy_t     joypad2_data;
	nes_bus_pkg::bus_req_t bus;
	nes_bus_pkg::data_t    cpu_din;
	logic                  pause_cpu;
	logic                  dmc_ack;
	logic                  odd_cycle;
	logic [2:0]            joypad_out;
	logic [1:0]            joypad_clock;

	integer             seed;       // $random state
	nes_bus_pkg::data_t last_byte;  // Expected open-bus value

	nes_bus_dma_top nes_bus_dma_top_inst (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.cpu          (cpu),
		.dmc_request  (dmc_request),
		.dmc_addr     (dmc_addr),
		.mem_din      (mem_din),
		.ppu_dout     (ppu_dout),
		.apu_status   (apu_status),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.bus          (bus),
		.cpu_din      (cpu_din),
		.pause_cpu    (pause_cpu),
		.dmc_ack      (dmc_ack),
		.odd_cycle    (odd_cycle),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = !clk;

	// Memory byte is low address byte XOR high address byte
	function automatic nes_bus_pkg::data_t model_byte(input nes_bus_pkg::addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	assign mem_din = model_byte(bus.addr);  // Combinational memory

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at time %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	// One CPU read cycle, checked at the falling edge
	task automatic cpu_read(input nes_bus_pkg::addr_t a, input nes_bus_pkg::data_t exp);
		@(posedge clk);
		cpu.addr <= a;
		cpu.rnw  <= 1'b1;
		@(negedge clk);
		assert (bus.rd && !bus.wr && bus.addr == a)
			else report_mismatch($sformatf("read of %h not on the bus", a));
		assert (cpu_din == exp)
			else report_mismatch($sformatf("read %h gave %h, expected %h", a, cpu_din, exp));
		// Pad clock only on the matching port
		assert (joypad_clock == {a == nes_bus_pkg::JOY2_ADDR, a == nes_bus_pkg::JOY1_ADDR})
			else report_mismatch($sformatf("joypad_clock %b on read of %h", joypad_clock, a));
		last_byte = exp;
	endtask

	task automatic cpu_write(input nes_bus_pkg::addr_t a, input nes_bus_pkg::data_t d);
		@(posedge clk);
		cpu.addr  <= a;
		cpu.rnw   <= 1'b0;
		cpu.wdata <= d;
		@(negedge clk);
		assert (bus.wr && !bus.rd && bus.addr == a && bus.wdata == d)
			else report_mismatch($sformatf("write %h to %h not on the bus", d, a));
		assert (joypad_clock == 2'b00)
			else report_mismatch("joypad_clock pulsed on a write");
	endtask

	`include "tb_tasks.svh"

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run($sformatf("Run did not finish within %0d clock periods", WATCHDOG_CYCLES));
	end

	initial begin
		seed         = 32'h82ed_c21a;
		reset        = 1'b1;
		ce           = 1'b1;  // CPU enable on every clock
		cpu          = '0;
		cpu.rnw      = 1'b1;
		dmc_request  = 1'b0;
		dmc_addr     = '0;
		ppu_dout     = PPU_VAL;
		apu_status   = APU_STATUS_VAL;
		joypad1_data = '0;
		joypad2_data = '0;
		last_byte    = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		check_reset_state();
		decode_reads();
		joypad_port();
		sprite_page_copy();
		dmc_cut_in();
		$display("TEST PASSED");
		$finish;
	end

endmodule
